// File: rtl/vmem_pkg.sv
// Shared widths, depths and register map of the vertex-property store.
// Memory is 8192 x 32 bit, built from 1024-word tiles.
// Wishbone word address carries one extra top bit for the register region.
package vmem_pkg;

	// ------------------------------------------------------------------
	// Data path
	// ------------------------------------------------------------------
	localparam int DATA_W = 32;
	localparam int BYTE_W = 8;
	// One write enable per byte lane
	localparam int SEL_W = DATA_W / BYTE_W;

	// ------------------------------------------------------------------
	// Memory geometry and timing
	// ------------------------------------------------------------------
	// 8192 words over the whole store
	localparam int MEM_ADDR_W = 13;
	// 1024 words per tile
	localparam int LEAF_ADDR_W = 10;
	// Enabled read at a tile to valid dout
	localparam int READ_LATENCY = 2;
	// Wait counter in the bus control, wide enough for READ_LATENCY
	localparam int LAT_CNT_W = $clog2(READ_LATENCY + 1);

	// ------------------------------------------------------------------
	// Bus and register map
	// ------------------------------------------------------------------
	// Top bit set selects the register region
	localparam int WB_ADDR_W = MEM_ADDR_W + 1;
	// Bit 0 write 1 starts a fill, read gives busy
	localparam logic [MEM_ADDR_W-1:0] REG_CTRL = MEM_ADDR_W'(0);
	// Fill value, full 32 bits
	localparam logic [MEM_ADDR_W-1:0] REG_FILL = MEM_ADDR_W'(1);

endpackage : vmem_pkg

// File: rtl/spram_leaf.sv
// One single-port RAM tile, behavioral, read-first on a write.
// Storage has no reset; only the read pipeline is cleared.
// dout is valid READ_LATENCY cycles after an enabled access and holds after.
`timescale 1ns/1ns

module spram_leaf #(
	parameter int ADDR_W = vmem_pkg::LEAF_ADDR_W
) (
	input  logic                         ap_clk,
	input  logic                         rst_n,
	input  logic                         en,
	input  logic [vmem_pkg::SEL_W-1:0]   we,
	input  logic [ADDR_W-1:0]            addr,
	input  logic [vmem_pkg::DATA_W-1:0]  din,
	output logic [vmem_pkg::DATA_W-1:0]  dout
);

	import vmem_pkg::*;

	// Tile storage
	logic [DATA_W-1:0] mem [2**ADDR_W];
	// Read pipeline, stage 0 is the array output register
	logic [DATA_W-1:0] rd_pipe [READ_LATENCY];

	// Byte-lane writes, untouched lanes keep their old value
	always_ff @(posedge ap_clk) begin
		if (en) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (we[b]) begin
					mem[addr][b*BYTE_W +: BYTE_W] <= din[b*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// Stage 0 loads only on en and then holds
	// Later stages shift every cycle, so the last one settles and holds too
	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < READ_LATENCY; i++) begin
				rd_pipe[i] <= '0;
			end
		end else begin
			if (en) begin
				rd_pipe[0] <= mem[addr];
			end
			for (int i = 1; i < READ_LATENCY; i++) begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
		end
	end

	assign dout = rd_pipe[READ_LATENCY-1];

	// Address must be known whenever the tile is enabled
	a_addr_known: assert property (@(posedge ap_clk) disable iff (!rst_n)
		en |-> !$isunknown(addr));

endmodule : spram_leaf

// File: rtl/spram_split.sv
// Recursive splitter over the word address space.
// Halves the space per level until a tile of LEAF_ADDR_W remains.
// Adds no cycles; read data is steered by a bank bit delayed READ_LATENCY
// cycles, so a new access may start while older reads are in flight.
`timescale 1ns/1ns

module spram_split #(
	parameter int ADDR_W = vmem_pkg::MEM_ADDR_W
) (
	input  logic                         ap_clk,
	input  logic                         rst_n,
	input  logic                         en,
	input  logic [vmem_pkg::SEL_W-1:0]   we,
	input  logic [ADDR_W-1:0]            addr,
	input  logic [vmem_pkg::DATA_W-1:0]  din,
	output logic [vmem_pkg::DATA_W-1:0]  dout
);

	import vmem_pkg::*;

	generate
		if (ADDR_W > LEAF_ADDR_W) begin : g_split

			// ----------------------------------------------------------
			// Request steering
			// ----------------------------------------------------------
			logic                 bank;
			logic                 en_lo;
			logic                 en_hi;
			logic [SEL_W-1:0]     we_lo;
			logic [SEL_W-1:0]     we_hi;
			logic [ADDR_W-2:0]    addr_sub;
			logic [DATA_W-1:0]    dout_lo;
			logic [DATA_W-1:0]    dout_hi;
			// Bank bit of each read still in the pipeline
			logic [READ_LATENCY-1:0] bank_q;

			assign bank     = addr[ADDR_W-1];
			assign addr_sub = addr[ADDR_W-2:0];

			// Idle half sees no enable and no byte mask
			assign en_lo = en & ~bank;
			assign en_hi = en & bank;
			assign we_lo = bank ? '0 : we;
			assign we_hi = bank ? we : '0;

			// ----------------------------------------------------------
			// Bank select delay line
			// ----------------------------------------------------------
			// Mirrors the tile pipeline: stage 0 loads on en, rest shift
			always_ff @(posedge ap_clk or negedge rst_n) begin
				if (!rst_n) begin
					bank_q <= '0;
				end else begin
					if (en) begin
						bank_q[0] <= bank;
					end
					for (int i = 1; i < READ_LATENCY; i++) begin
						bank_q[i] <= bank_q[i-1];
					end
				end
			end

			// Select by the bank of the read that is due now, not by addr
			assign dout = bank_q[READ_LATENCY-1] ? dout_hi : dout_lo;

			spram_split #(
				.ADDR_W (ADDR_W - 1)
			) u_lo (
				.ap_clk (ap_clk),
				.rst_n  (rst_n),
				.en     (en_lo),
				.we     (we_lo),
				.addr   (addr_sub),
				.din    (din),
				.dout   (dout_lo)
			);

			spram_split #(
				.ADDR_W (ADDR_W - 1)
			) u_hi (
				.ap_clk (ap_clk),
				.rst_n  (rst_n),
				.en     (en_hi),
				.we     (we_hi),
				.addr   (addr_sub),
				.din    (din),
				.dout   (dout_hi)
			);

		end else begin : g_leaf

			// Bottom of the recursion, one tile
			spram_leaf #(
				.ADDR_W (ADDR_W)
			) u_leaf (
				.ap_clk (ap_clk),
				.rst_n  (rst_n),
				.en     (en),
				.we     (we),
				.addr   (addr),
				.din    (din),
				.dout   (dout)
			);

		end
	endgenerate

	// A byte mask with no enable would be lost at the tile
	a_we_needs_en: assert property (@(posedge ap_clk) disable iff (!rst_n)
		(we != '0) |-> en);

endmodule : spram_split

// File: rtl/fill_sweep.sv
// Walks every memory word once, one per cycle, while a fill runs.
// A fill takes exactly 2**MEM_ADDR_W cycles; done pulses the cycle after.
// start during a running fill restarts the walk from word 0.
`timescale 1ns/1ns

module fill_sweep (
	input  logic                           ap_clk,
	input  logic                           rst_n,
	input  logic                           start,
	output logic                           fill_en,
	output logic [vmem_pkg::MEM_ADDR_W-1:0] fill_addr,
	output logic                           busy,
	output logic                           done
);

	import vmem_pkg::*;

	logic                  running;
	logic [MEM_ADDR_W-1:0] addr_q;
	logic                  last;

	// Last word of the store
	assign last = (addr_q == '1);

	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			addr_q  <= '0;
			done    <= 1'b0;
		end else begin
			done <= running & last;
			if (start) begin
				running <= 1'b1;
				addr_q  <= '0;
			end else if (running) begin
				// Counter wraps to 0 as the walk ends
				addr_q <= addr_q + 1'b1;
				if (last) begin
					running <= 1'b0;
				end
			end
		end
	end

	assign fill_en   = running;
	assign fill_addr = addr_q;
	assign busy      = running;

endmodule : fill_sweep

// File: rtl/vmem_wb_ctrl.sv
// Wishbone classic slave for the vertex store and its two registers.
// Memory reads ack READ_LATENCY cycles after accept, all else after one.
// Memory requests wait while a fill is pending; registers stay reachable.
// No error responses; unmapped register offsets read zero.
`timescale 1ns/1ns

module vmem_wb_ctrl (
	input  logic                            ap_clk,
	input  logic                            rst_n,
	input  logic                            cyc,
	input  logic                            stb,
	input  logic                            we,
	input  logic [vmem_pkg::WB_ADDR_W-1:0]  adr,
	input  logic [vmem_pkg::DATA_W-1:0]     dat_w,
	input  logic [vmem_pkg::SEL_W-1:0]      sel,
	output logic                            ack,
	output logic [vmem_pkg::DATA_W-1:0]     dat_r,
	output logic                            mem_en,
	output logic [vmem_pkg::SEL_W-1:0]      mem_we,
	output logic [vmem_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [vmem_pkg::DATA_W-1:0]     mem_din,
	input  logic [vmem_pkg::DATA_W-1:0]     mem_dout,
	output logic                            fill_start,
	input  logic [vmem_pkg::MEM_ADDR_W-1:0] fill_addr,
	input  logic                            fill_en,
	input  logic                            fill_busy,
	input  logic                            fill_done
);

	import vmem_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_WAIT
	} state_t;

	state_t                state;
	logic [LAT_CNT_W-1:0]  lat_cnt;
	logic                  accept;
	logic                  reg_hit;
	logic [MEM_ADDR_W-1:0] reg_off;
	// Fill requested or still sweeping
	logic                  fill_pending;
	logic                  fill_active;
	// Registered bus request toward memory
	logic                  bus_en_q;
	logic [SEL_W-1:0]      bus_we_q;
	logic [MEM_ADDR_W-1:0] bus_addr_q;
	logic [DATA_W-1:0]     bus_din_q;
	// Register read in progress and its data
	logic                  reg_rd_q;
	logic [DATA_W-1:0]     reg_rdata_q;
	logic [DATA_W-1:0]     fill_val;

	assign reg_hit     = adr[WB_ADDR_W-1];
	assign reg_off     = adr[MEM_ADDR_W-1:0];
	assign fill_active = fill_pending | fill_busy;

	// Only from idle, never in the ack cycle, memory held off during a fill
	assign accept = (state == ST_IDLE) & ~ack & cyc & stb & (reg_hit | ~fill_active);

	// ------------------------------------------------------------------
	// Transfer FSM and ack timing
	// ------------------------------------------------------------------
	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			lat_cnt    <= '0;
			ack        <= 1'b0;
			bus_en_q   <= 1'b0;
			reg_rd_q   <= 1'b0;
			fill_start <= 1'b0;
		end else begin
			// Pulses by default
			ack        <= 1'b0;
			bus_en_q   <= 1'b0;
			fill_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state    <= ST_WAIT;
						reg_rd_q <= reg_hit;
						bus_en_q <= ~reg_hit;
						// Memory reads wait out the tile pipeline
						lat_cnt  <= (~reg_hit & ~we) ? LAT_CNT_W'(READ_LATENCY - 1) : '0;
						fill_start <= reg_hit & we & (reg_off == REG_CTRL) & sel[0] &
							dat_w[0] & ~fill_active;
					end
				end
				ST_WAIT: begin
					if (lat_cnt == '0) begin
						ack   <= 1'b1;
						state <= ST_IDLE;
					end else begin
						lat_cnt <= lat_cnt - 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Request payload, captured on accept
	always_ff @(posedge ap_clk) begin
		if (accept) begin
			bus_we_q   <= we ? sel : '0;
			bus_addr_q <= reg_off;
			bus_din_q  <= dat_w;
			if (reg_off == REG_CTRL) begin
				reg_rdata_q <= {{(DATA_W-1){1'b0}}, fill_active};
			end else if (reg_off == REG_FILL) begin
				reg_rdata_q <= fill_val;
			end else begin
				reg_rdata_q <= '0;
			end
		end
	end

	// ------------------------------------------------------------------
	// Fill value register and fill tracking
	// ------------------------------------------------------------------
	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			fill_val     <= '0;
			fill_pending <= 1'b0;
		end else begin
			if (accept & reg_hit & we & (reg_off == REG_FILL)) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (sel[b]) begin
						fill_val[b*BYTE_W +: BYTE_W] <= dat_w[b*BYTE_W +: BYTE_W];
					end
				end
			end
			// Set with the sweep start and cleared by done after busy drops
			if (fill_start) begin
				fill_pending <= 1'b1;
			end else if (fill_done) begin
				fill_pending <= 1'b0;
			end
		end
	end

	// Memory port goes to the sweep while it runs, full byte mask
	assign mem_en   = fill_en | bus_en_q;
	assign mem_we   = fill_en ? '1 : (bus_en_q ? bus_we_q : '0);
	assign mem_addr = fill_en ? fill_addr : bus_addr_q;
	assign mem_din  = fill_en ? fill_val : bus_din_q;

	assign dat_r = reg_rd_q ? reg_rdata_q : mem_dout;

	// ------------------------------------------------------------------
	// Bus protocol checks
	// ------------------------------------------------------------------
	a_ack_in_cycle: assert property (@(posedge ap_clk) disable iff (!rst_n)
		ack |-> cyc);
	a_ack_single: assert property (@(posedge ap_clk) disable iff (!rst_n)
		ack |=> !ack);
	// Sweep finishes only a fill this block started
	a_done_expected: assert property (@(posedge ap_clk) disable iff (!rst_n)
		fill_done |-> fill_pending);

endmodule : vmem_wb_ctrl

// File: rtl/vmem_top.sv
// Vertex-property store, 8192 x 32 bit behind a Wishbone classic slave.
// adr top bit set reaches the control and fill-value registers.
// Master holds its request until ack; stb may stay high into the next one.
`timescale 1ns/1ns

module vmem_top (
	input  logic                           ap_clk,
	input  logic                           rst_n,
	input  logic                           cyc,
	input  logic                           stb,
	input  logic                           we,
	input  logic [vmem_pkg::WB_ADDR_W-1:0] adr,
	input  logic [vmem_pkg::DATA_W-1:0]    dat_w,
	input  logic [vmem_pkg::SEL_W-1:0]     sel,
	output logic [vmem_pkg::DATA_W-1:0]    dat_r,
	output logic                           ack
);

	import vmem_pkg::*;

	// Memory port
	logic                  mem_en;
	logic [SEL_W-1:0]      mem_we;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0]     mem_din;
	logic [DATA_W-1:0]     mem_dout;
	// Fill sweep
	logic                  fill_start;
	logic                  fill_en;
	logic [MEM_ADDR_W-1:0] fill_addr;
	logic                  fill_busy;
	logic                  fill_done;

	vmem_wb_ctrl u_ctrl (
		.ap_clk     (ap_clk),
		.rst_n      (rst_n),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.sel        (sel),
		.ack        (ack),
		.dat_r      (dat_r),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_din    (mem_din),
		.mem_dout   (mem_dout),
		.fill_start (fill_start),
		.fill_addr  (fill_addr),
		.fill_en    (fill_en),
		.fill_busy  (fill_busy),
		.fill_done  (fill_done)
	);

	fill_sweep u_fill (
		.ap_clk    (ap_clk),
		.rst_n     (rst_n),
		.start     (fill_start),
		.fill_en   (fill_en),
		.fill_addr (fill_addr),
		.busy      (fill_busy),
		.done      (fill_done)
	);

	// Whole store, split down to 1024-word tiles
	spram_split #(
		.ADDR_W (MEM_ADDR_W)
	) u_mem (
		.ap_clk (ap_clk),
		.rst_n  (rst_n),
		.en     (mem_en),
		.we     (mem_we),
		.addr   (mem_addr),
		.din    (mem_din),
		.dout   (mem_dout)
	);

endmodule : vmem_top

// File: bench/tb_clkgen.sv
// Clock and reset source for the testbench.
// Reset is active low, held over RESET_CYCLES rising edges.
`timescale 1ns/1ns

module tb_clkgen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule : tb_clkgen

// File: bench/vmem_tb.sv
// Testbench for the vertex-property store behind Wishbone classic.
// Inputs change on the falling edge; each request is held until ack.
// A shadow array predicts every read, a separate process compares.
`timescale 1ns/1ns

module vmem_tb;

	import vmem_pkg::*;

	localparam int FILL_WORDS = 2 ** MEM_ADDR_W;
	localparam int N_WORDS    = 64;
	localparam int N_ALT      = 8;
	localparam int N_FILL_RD  = 32;
	localparam int N_OVR      = 16;
	// Upper bound on transfers outside the two fills
	localparam int XFER_COUNT = 400;
	localparam int WATCHDOG_CYCLES = 2 * (XFER_COUNT * 10 + 2 * FILL_WORDS);
	localparam logic [WB_ADDR_W-1:0] CTRL_ADR = {1'b1, REG_CTRL};
	localparam logic [WB_ADDR_W-1:0] FILL_ADR = {1'b1, REG_FILL};

	logic                 clk;
	logic                 rst_n;
	logic                 cyc;
	logic                 stb;
	logic                 we;
	logic [WB_ADDR_W-1:0] adr;
	logic [DATA_W-1:0]    dat_w;
	logic [SEL_W-1:0]     sel;
	logic [DATA_W-1:0]    dat_r;
	logic                 ack;

	// Expected memory contents
	logic [DATA_W-1:0] shadow [FILL_WORDS];
	logic [31:0]       rng = 32'h6139_fb41;
	int                cycle_cnt = 0;
	int                checks = 0;
	int                check_errors = 0;
	int                other_errors = 0;
	// Reads waiting for the compare process
	string             name_q [$];
	logic [DATA_W-1:0] exp_q [$];
	logic [DATA_W-1:0] act_q [$];
	string             cmp_name;
	logic [DATA_W-1:0] cmp_exp;
	logic [DATA_W-1:0] cmp_act;

	tb_clkgen u_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	vmem_top u_vmem_top (
		.ap_clk (clk),
		.rst_n  (rst_n),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.dat_w  (dat_w),
		.sel    (sel),
		.dat_r  (dat_r),
		.ack    (ack)
	);

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Enabled lanes take the new byte, the rest keep the old one
	function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [SEL_W-1:0] lanes);
		logic [DATA_W-1:0] w;
		w = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (lanes[b]) begin
				w[b*BYTE_W +: BYTE_W] = new_w[b*BYTE_W +: BYTE_W];
			end
		end
		return w;
	endfunction

	function automatic void model_write(input logic [MEM_ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d, input logic [SEL_W-1:0] s);
		shadow[a] = merge_lanes(shadow[a], d, s);
	endfunction

	function automatic void model_fill(input logic [DATA_W-1:0] v);
		for (int i = 0; i < FILL_WORDS; i++) begin
			shadow[i] = v;
		end
	endfunction

	function automatic logic [DATA_W-1:0] expected_word(input logic [MEM_ADDR_W-1:0] a);
		return shadow[a];
	endfunction

	// ------------------------------------------------------------------
	// Bus tasks
	// ------------------------------------------------------------------
	task automatic next_random(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	// Called at a falling edge, returns at one
	task automatic bus_transfer(input logic wr, input logic [WB_ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d, input logic [SEL_W-1:0] s,
		output logic [DATA_W-1:0] rd);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = wr;
		adr   = a;
		dat_w = d;
		sel   = s;
		@(negedge clk);
		while (ack !== 1'b1) @(negedge clk);
		rd = dat_r;
		// Transfer ends at the rising edge that samples ack
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic write_word(input logic [MEM_ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d, input logic [SEL_W-1:0] s);
		logic [DATA_W-1:0] rd;
		bus_transfer(1'b1, {1'b0, a}, d, s, rd);
		model_write(a, d, s);
	endtask

	task automatic compare_read(input string name, input logic [WB_ADDR_W-1:0] a,
		input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] rd;
		bus_transfer(1'b0, a, '0, '1, rd);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(rd);
	endtask

	// ------------------------------------------------------------------
	// Compare process
	// ------------------------------------------------------------------
	always @(posedge clk) begin
		while (exp_q.size() > 0) begin
			cmp_name = name_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_act  = act_q.pop_front();
			checks   = checks + 1;
			assert (cmp_act === cmp_exp) else begin
				check_errors = check_errors + 1;
				$display("Error %s: expected %08h, actual %08h", cmp_name, cmp_exp, cmp_act);
			end
		end
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	initial begin : stimulus
		logic [31:0]           r;
		logic [31:0]           s;
		logic [DATA_W-1:0]     rd;
		logic [DATA_W-1:0]     fill_a;
		logic [DATA_W-1:0]     fill_b;
		logic [MEM_ADDR_W-1:0] a;
		logic [MEM_ADDR_W-1:0] wr_addr [N_WORDS];
		logic [MEM_ADDR_W-1:0] ovr_addr [N_OVR];
		int                    polls;
		int                    issue_cyc;
		int                    m;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_w = '0;
		sel   = '0;
		wait (rst_n === 1'b1);
		@(negedge clk);

		// Idle state out of reset
		assert (ack === 1'b0) else begin
			other_errors = other_errors + 1;
			$display("ack is high after reset with no transfer");
		end
		compare_read("reset_busy", CTRL_ADR, 32'h0);

		// Full words, tile index in the top address bits
		for (int i = 0; i < N_WORDS; i++) begin
			next_random(r);
			a = MEM_ADDR_W'(r);
			a[MEM_ADDR_W-1 -: 3] = 3'(i % 8);
			wr_addr[i] = a;
			next_random(r);
			write_word(a, r, '1);
		end
		for (int i = 0; i < N_WORDS; i++) begin
			compare_read("full_word", {1'b0, wr_addr[i]}, expected_word(wr_addr[i]));
		end

		// Random byte lanes over known words
		for (int i = 0; i < N_WORDS; i++) begin
			next_random(r);
			next_random(s);
			write_word(wr_addr[i], r, s[SEL_W-1:0]);
		end
		for (int i = 0; i < N_WORDS; i++) begin
			compare_read("byte_lanes", {1'b0, wr_addr[i]}, expected_word(wr_addr[i]));
		end

		// Index 8k+m sits in the low half, 8k+m+4 in the high half
		for (int k = 0; k < N_ALT; k++) begin
			m = 8 * k + (k % 4);
			compare_read("alt_bank_lo", {1'b0, wr_addr[m]}, expected_word(wr_addr[m]));
			compare_read("alt_bank_hi", {1'b0, wr_addr[m+4]}, expected_word(wr_addr[m+4]));
		end

		// ------------------------------------------------------------------
		// Registers and first fill
		// ------------------------------------------------------------------
		next_random(fill_a);
		bus_transfer(1'b1, FILL_ADR, fill_a, '1, rd);
		compare_read("fill_reg", FILL_ADR, fill_a);
		bus_transfer(1'b1, CTRL_ADR, 32'h1, '1, rd);
		model_fill(fill_a);
		compare_read("fill_busy", CTRL_ADR, 32'h1);
		polls = 0;
		do begin
			bus_transfer(1'b0, CTRL_ADR, '0, '1, rd);
			polls = polls + 1;
		end while (rd[0] === 1'b1 && polls < FILL_WORDS);
		assert (rd === 32'h0) else begin
			other_errors = other_errors + 1;
			$display("Busy flag did not clear after %0d polls", polls);
		end

		// Filled words, then overrides on top
		for (int i = 0; i < N_FILL_RD; i++) begin
			next_random(r);
			a = MEM_ADDR_W'(r);
			compare_read("after_fill", {1'b0, a}, expected_word(a));
		end
		for (int i = 0; i < N_OVR; i++) begin
			next_random(r);
			ovr_addr[i] = MEM_ADDR_W'(r);
			next_random(r);
			next_random(s);
			write_word(ovr_addr[i], r, s[SEL_W-1:0]);
		end
		for (int i = 0; i < N_OVR; i++) begin
			compare_read("override", {1'b0, ovr_addr[i]}, expected_word(ovr_addr[i]));
		end

		// Memory read held off by a running fill
		next_random(fill_b);
		bus_transfer(1'b1, FILL_ADR, fill_b, '1, rd);
		bus_transfer(1'b1, CTRL_ADR, 32'h1, '1, rd);
		model_fill(fill_b);
		next_random(r);
		a = MEM_ADDR_W'(r);
		issue_cyc = cycle_cnt;
		compare_read("read_in_fill", {1'b0, a}, expected_word(a));
		assert (cycle_cnt - issue_cyc >= FILL_WORDS - 8) else begin
			other_errors = other_errors + 1;
			$display("Memory read finished after %0d cycles, before the fill could end",
				cycle_cnt - issue_cyc);
		end
		compare_read("busy_after_fill", CTRL_ADR, 32'h0);

		// Let the compare process drain
		repeat (2) @(negedge clk);
		$display("Checks: %0d, read errors: %0d, other errors: %0d",
			checks, check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Bound from transfer count plus two full fills
	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, run did not finish (read errors: %0d, other: %0d)",
			WATCHDOG_CYCLES, check_errors, other_errors);
		$display("*** FAILED ***");
		$finish;
	end

endmodule : vmem_tb

// File: compile.f
rtl/vmem_pkg.sv
rtl/spram_leaf.sv
rtl/spram_split.sv
rtl/fill_sweep.sv
rtl/vmem_wb_ctrl.sv
rtl/vmem_top.sv
bench/tb_clkgen.sv
bench/vmem_tb.sv

// File: Makefile
# Verilator build and run of the vertex-property store testbench
# Any variable can be overridden, e.g. make LOG=run2.log

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= vmem_tb
RTL_TOP   ?= vmem_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "No pass result in log"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
